/* mgmt_pkg.sv */
package mgmt_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths

	localparam ADDR_WIDTH			= 16;
	localparam DATA_WIDTH			= 16;
	localparam SMOL_OFFSET_WIDTH	= 10;
	localparam BIG_OFFSET_WIDTH		= 12;

	////////////////////////////////////////////////////////////
	// Address map

	// One byte address, read as a 1 kB window or a 4 kB window
	typedef union packed {
		struct packed {
			logic							region;
			logic [4:0]						dev;
			logic [SMOL_OFFSET_WIDTH-1:0]	offset;
		} smol;
		struct packed {
			logic							region;
			logic [2:0]						dev;
			logic [BIG_OFFSET_WIDTH-1:0]	offset;
		} big;
	} mgmt_addr_t;

	// Slots in the small window
	localparam logic [4:0] SMOL_SYSINFO	= 5'd0;
	localparam logic [4:0] SMOL_LEDS	= 5'd1;
	localparam logic [4:0] SMOL_IRQ		= 5'd2;

	// Slots in the big window
	localparam logic [2:0] BIG_EXT		= 3'd0;

	// Device select indices, internal blocks sit below the external port
	localparam NUM_DEVS		= 4;
	localparam DEV_SYSINFO	= 0;
	localparam DEV_LEDS		= 1;
	localparam DEV_IRQ		= 2;
	localparam DEV_EXT		= 3;
	localparam NUM_INT_DEVS	= NUM_DEVS - 1;

	////////////////////////////////////////////////////////////
	// Register offsets

	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_SYS_ID		= 10'h000;
	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_FAN0		= 10'h002;
	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_FAN1		= 10'h004;
	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_LED_IN		= 10'h000;
	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_LED_OUT	= 10'h002;
	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_IRQ_STATUS	= 10'h000;
	localparam logic [SMOL_OFFSET_WIDTH-1:0] REG_IRQ_ENABLE	= 10'h002;

	// Board identification word
	localparam logic [DATA_WIDTH-1:0] SYSINFO_ID = 16'h7c0e;

endpackage

/* mgmt_apb_decoder.sv */
module mgmt_apb_decoder
	import mgmt_pkg::*;
(
	// Clock and reset only feed the bound checks
	input wire								sys_clk,
	input wire								rst,

	// Upstream requester
	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input wire [ADDR_WIDTH-1:0]				paddr,
	input wire [DATA_WIDTH-1:0]				pwdata,
	output logic [DATA_WIDTH-1:0]			prdata,
	output logic							pready,
	output logic							pslverr,

	// Internal devices
	output logic [NUM_DEVS-1:0]				dev_psel,
	output logic							dev_penable,
	output logic							dev_pwrite,
	output logic [SMOL_OFFSET_WIDTH-1:0]	dev_paddr,
	output logic [DATA_WIDTH-1:0]			dev_pwdata,
	input wire [NUM_INT_DEVS-1:0][DATA_WIDTH-1:0]	dev_prdata,
	input wire [NUM_INT_DEVS-1:0]			dev_pready,
	input wire [NUM_INT_DEVS-1:0]			dev_pslverr,

	// External big-window peripheral
	output logic							ext_psel,
	output logic							ext_penable,
	output logic							ext_pwrite,
	output logic [BIG_OFFSET_WIDTH-1:0]		ext_paddr,
	output logic [DATA_WIDTH-1:0]			ext_pwdata,
	input wire [DATA_WIDTH-1:0]				ext_prdata,
	input wire								ext_pready,
	input wire								ext_pslverr
);

	mgmt_addr_t	addr;
	logic		unmapped;

	assign addr = paddr;

	////////////////////////////////////////////////////////////
	// Slot decode

	always_comb begin
		dev_psel	= '0;
		unmapped	= 1'b0;
		if(psel) begin
			// Region bit lives at the same place in both views
			if(!addr.smol.region) begin
				case(addr.smol.dev)
					SMOL_SYSINFO:	dev_psel[DEV_SYSINFO]	= 1'b1;
					SMOL_LEDS:		dev_psel[DEV_LEDS]		= 1'b1;
					SMOL_IRQ:		dev_psel[DEV_IRQ]		= 1'b1;
					default:		unmapped				= 1'b1;
				endcase
			end
			else if(addr.big.dev == BIG_EXT)
				dev_psel[DEV_EXT]	= 1'b1;
			else
				unmapped			= 1'b1;
		end
	end

	// Shared request lines
	assign dev_penable	= penable;
	assign dev_pwrite	= pwrite;
	assign dev_paddr	= addr.smol.offset;
	assign dev_pwdata	= pwdata;

	// External port sees only its own transfers
	assign ext_psel		= dev_psel[DEV_EXT];
	assign ext_penable	= penable & dev_psel[DEV_EXT];
	assign ext_pwrite	= pwrite;
	assign ext_paddr	= addr.big.offset;
	assign ext_pwdata	= pwdata;

	////////////////////////////////////////////////////////////
	// Response mux

	always_comb begin
		prdata	= '0;
		pready	= 1'b1;
		pslverr	= 1'b0;

		// External port may stretch the access cycle
		if(dev_psel[DEV_EXT]) begin
			prdata	= ext_prdata;
			pready	= ext_pready;
			pslverr	= ext_pslverr;
		end
		// Nobody home, fail right away with zero data
		else if(unmapped)
			pslverr	= 1'b1;
		else begin
			for(int i = 0; i < NUM_INT_DEVS; i++) begin
				if(dev_psel[i]) begin
					prdata	= dev_prdata[i];
					pready	= dev_pready[i];
					pslverr	= dev_pslverr[i];
				end
			end
		end
	end

endmodule

/* fan_tachometer.sv */
module fan_tachometer #(
	parameter REFCLK_HZ		= 250000000,
	parameter GATE_CYCLES	= 125000000
) (
	input wire			sys_clk,
	input wire			rst,
	input wire			tach,
	output logic [15:0]	rpm
);

	localparam GATE_W	= $clog2(GATE_CYCLES);
	localparam EDGE_W	= $clog2(GATE_CYCLES + 1);

	// RPM per counted edge, two tach pulses per revolution
	localparam longint unsigned RPM_SCALE = (64'd30 * REFCLK_HZ) / GATE_CYCLES;

	logic [1:0]			tach_sync;
	logic				tach_prev;
	logic				tach_rise;
	logic [GATE_W-1:0]	gate_count;
	logic [EDGE_W-1:0]	edge_count;

	assign tach_rise = tach_sync[1] & ~tach_prev;

	////////////////////////////////////////////////////////////
	// Input sync and gate window counting

	always_ff @(posedge sys_clk) begin
		if(rst) begin
			tach_sync	<= '0;
			tach_prev	<= 1'b0;
			gate_count	<= '0;
			edge_count	<= '0;
			rpm			<= '0;
		end
		else begin
			// Two flop synchronizer, fan tach is asynchronous
			tach_sync	<= {tach_sync[0], tach};
			tach_prev	<= tach_sync[1];

			if(gate_count == GATE_W'(GATE_CYCLES - 1)) begin
				// Window done, publish and start over
				gate_count	<= '0;
				rpm			<= 16'(edge_count * RPM_SCALE);
				edge_count	<= EDGE_W'(tach_rise);
			end
			else begin
				gate_count	<= gate_count + 1'b1;
				if(tach_rise)
					edge_count	<= edge_count + 1'b1;
			end
		end
	end

endmodule

/* apb_sysinfo.sv */
module apb_sysinfo
	import mgmt_pkg::*;
(
	input wire								sys_clk,
	input wire								rst,

	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input wire [SMOL_OFFSET_WIDTH-1:0]		paddr,
	output logic [DATA_WIDTH-1:0]			prdata,
	output logic							pready,
	output logic							pslverr,

	input wire [15:0]						fan0_rpm,
	input wire [15:0]						fan1_rpm
);

	logic [DATA_WIDTH-1:0]	fan0_reg;
	logic [DATA_WIDTH-1:0]	fan1_reg;
	logic					addr_ok;

	// Snapshot the speeds so a read never sees them mid-update
	always_ff @(posedge sys_clk) begin
		if(rst) begin
			fan0_reg	<= '0;
			fan1_reg	<= '0;
		end
		else begin
			fan0_reg	<= fan0_rpm;
			fan1_reg	<= fan1_rpm;
		end
	end

	// Register readback
	always_comb begin
		addr_ok	= 1'b1;
		case(paddr)
			REG_SYS_ID:	prdata	= SYSINFO_ID;
			REG_FAN0:	prdata	= fan0_reg;
			REG_FAN1:	prdata	= fan1_reg;
			default: begin
				prdata	= '0;
				addr_ok	= 1'b0;
			end
		endcase
	end

	// Everything here is read only
	assign pready	= 1'b1;
	assign pslverr	= psel & penable & (pwrite | ~addr_ok);

endmodule

/* apb_led_status.sv */
module apb_led_status
	import mgmt_pkg::*;
(
	input wire								sys_clk,
	input wire								rst,

	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input wire [SMOL_OFFSET_WIDTH-1:0]		paddr,
	output logic [DATA_WIDTH-1:0]			prdata,
	output logic							pready,
	output logic							pslverr,

	input wire [11:0]						trig_in_led,
	input wire [11:0]						trig_out_led,
	input wire [3:0]						relay_state
);

	logic [11:0]	in_flipped;
	logic [11:0]	out_gated;
	logic [11:0]	in_reg;
	logic [11:0]	out_reg;
	logic			addr_ok;

	////////////////////////////////////////////////////////////
	// LED shaping

	// Expander wires the input LEDs MSB first
	always_comb begin
		for(int i = 0; i < 12; i++)
			in_flipped[i]	= trig_in_led[11 - i];
	end

	// Upper four outputs are dark while their relay is switched
	assign out_gated = {trig_out_led[11:8] & ~relay_state, trig_out_led[7:0]};

	always_ff @(posedge sys_clk) begin
		if(rst) begin
			in_reg	<= '0;
			out_reg	<= '0;
		end
		else begin
			in_reg	<= in_flipped;
			out_reg	<= out_gated;
		end
	end

	// Readback, top nibble always zero
	always_comb begin
		addr_ok	= 1'b1;
		case(paddr)
			REG_LED_IN:		prdata	= {4'h0, in_reg};
			REG_LED_OUT:	prdata	= {4'h0, out_reg};
			default: begin
				prdata	= '0;
				addr_ok	= 1'b0;
			end
		endcase
	end

	assign pready	= 1'b1;
	assign pslverr	= psel & penable & (pwrite | ~addr_ok);

endmodule

/* apb_irq_status.sv */
module apb_irq_status
	import mgmt_pkg::*;
#(
	parameter IRQ_COUNT = 4
) (
	input wire								sys_clk,
	input wire								rst,

	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input wire [SMOL_OFFSET_WIDTH-1:0]		paddr,
	input wire [DATA_WIDTH-1:0]				pwdata,
	output logic [DATA_WIDTH-1:0]			prdata,
	output logic							pready,
	output logic							pslverr,

	input wire [IRQ_COUNT-1:0]				irq_events,
	output logic							irq
);

	logic [IRQ_COUNT-1:0]	status;
	logic [IRQ_COUNT-1:0]	enable;
	logic [IRQ_COUNT-1:0]	clear_mask;
	logic					access;
	logic					addr_ok;

	// Single-cycle access phase, pready never drops
	assign access	= psel & penable;
	assign pready	= 1'b1;

	always_comb begin
		addr_ok	= 1'b1;
		case(paddr)
			REG_IRQ_STATUS:	prdata	= DATA_WIDTH'(status);
			REG_IRQ_ENABLE:	prdata	= DATA_WIDTH'(enable);
			default: begin
				prdata	= '0;
				addr_ok	= 1'b0;
			end
		endcase
	end

	assign pslverr = access & ~addr_ok;

	// Bits written as one in the status register get cleared
	assign clear_mask = (access && pwrite && paddr == REG_IRQ_STATUS) ?
		pwdata[IRQ_COUNT-1:0] : '0;

	////////////////////////////////////////////////////////////
	// Sticky status and interrupt pin

	always_ff @(posedge sys_clk) begin
		if(rst) begin
			status	<= '0;
			enable	<= '0;
			irq		<= 1'b0;
		end
		else begin
			// New event beats a clear in the same cycle
			status	<= (status & ~clear_mask) | irq_events;
			if(access && pwrite && paddr == REG_IRQ_ENABLE)
				enable	<= pwdata[IRQ_COUNT-1:0];
			irq		<= |(status & enable);
		end
	end

endmodule

/* management_subsystem.sv */
module management_subsystem
	import mgmt_pkg::*;
#(
	parameter REFCLK_HZ		= 250000000,
	parameter GATE_CYCLES	= 125000000,
	parameter IRQ_COUNT		= 4
) (
	input wire								sys_clk,
	input wire								rst,

	// Host side APB
	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input wire [ADDR_WIDTH-1:0]				paddr,
	input wire [DATA_WIDTH-1:0]				pwdata,
	output logic [DATA_WIDTH-1:0]			prdata,
	output logic							pready,
	output logic							pslverr,

	// Board status inputs
	input wire [1:0]						fan_tach,
	input wire [11:0]						trig_in_led,
	input wire [11:0]						trig_out_led,
	input wire [3:0]						relay_state,
	input wire [IRQ_COUNT-1:0]				irq_events,
	output logic							irq,

	// Off-block peripheral
	output logic							ext_psel,
	output logic							ext_penable,
	output logic							ext_pwrite,
	output logic [BIG_OFFSET_WIDTH-1:0]		ext_paddr,
	output logic [DATA_WIDTH-1:0]			ext_pwdata,
	input wire [DATA_WIDTH-1:0]				ext_prdata,
	input wire								ext_pready,
	input wire								ext_pslverr
);

	wire [NUM_DEVS-1:0]						dev_psel;
	wire									dev_penable;
	wire									dev_pwrite;
	wire [SMOL_OFFSET_WIDTH-1:0]			dev_paddr;
	wire [DATA_WIDTH-1:0]					dev_pwdata;
	wire [NUM_INT_DEVS-1:0][DATA_WIDTH-1:0]	dev_prdata;
	wire [NUM_INT_DEVS-1:0]					dev_pready;
	wire [NUM_INT_DEVS-1:0]					dev_pslverr;
	wire [15:0]								fan0_rpm;
	wire [15:0]								fan1_rpm;

	////////////////////////////////////////////////////////////
	// Address decode

	mgmt_apb_decoder decoder(
		.sys_clk(sys_clk),		.rst(rst),
		.psel(psel),			.penable(penable),		.pwrite(pwrite),
		.paddr(paddr),			.pwdata(pwdata),
		.prdata(prdata),		.pready(pready),		.pslverr(pslverr),
		.dev_psel(dev_psel),	.dev_penable(dev_penable),	.dev_pwrite(dev_pwrite),
		.dev_paddr(dev_paddr),	.dev_pwdata(dev_pwdata),
		.dev_prdata(dev_prdata),	.dev_pready(dev_pready),	.dev_pslverr(dev_pslverr),
		.ext_psel(ext_psel),	.ext_penable(ext_penable),	.ext_pwrite(ext_pwrite),
		.ext_paddr(ext_paddr),	.ext_pwdata(ext_pwdata),
		.ext_prdata(ext_prdata),	.ext_pready(ext_pready),	.ext_pslverr(ext_pslverr)
	);

	////////////////////////////////////////////////////////////
	// Fan speed

	fan_tachometer #(.REFCLK_HZ(REFCLK_HZ), .GATE_CYCLES(GATE_CYCLES)) tach0(
		.sys_clk(sys_clk),	.rst(rst),	.tach(fan_tach[0]),	.rpm(fan0_rpm)
	);

	fan_tachometer #(.REFCLK_HZ(REFCLK_HZ), .GATE_CYCLES(GATE_CYCLES)) tach1(
		.sys_clk(sys_clk),	.rst(rst),	.tach(fan_tach[1]),	.rpm(fan1_rpm)
	);

	////////////////////////////////////////////////////////////
	// Register blocks in the small window

	// Slot 0, board ID and fans
	apb_sysinfo sysinfo(
		.sys_clk(sys_clk),	.rst(rst),
		.psel(dev_psel[DEV_SYSINFO]),	.penable(dev_penable),	.pwrite(dev_pwrite),
		.paddr(dev_paddr),
		.prdata(dev_prdata[DEV_SYSINFO]),	.pready(dev_pready[DEV_SYSINFO]),
		.pslverr(dev_pslverr[DEV_SYSINFO]),
		.fan0_rpm(fan0_rpm),	.fan1_rpm(fan1_rpm)
	);

	// Slot 1, front panel LEDs
	apb_led_status leds(
		.sys_clk(sys_clk),	.rst(rst),
		.psel(dev_psel[DEV_LEDS]),	.penable(dev_penable),	.pwrite(dev_pwrite),
		.paddr(dev_paddr),
		.prdata(dev_prdata[DEV_LEDS]),	.pready(dev_pready[DEV_LEDS]),
		.pslverr(dev_pslverr[DEV_LEDS]),
		.trig_in_led(trig_in_led),	.trig_out_led(trig_out_led),	.relay_state(relay_state)
	);

	// Slot 2, interrupt status
	apb_irq_status #(.IRQ_COUNT(IRQ_COUNT)) irqstat(
		.sys_clk(sys_clk),	.rst(rst),
		.psel(dev_psel[DEV_IRQ]),	.penable(dev_penable),	.pwrite(dev_pwrite),
		.paddr(dev_paddr),	.pwdata(dev_pwdata),
		.prdata(dev_prdata[DEV_IRQ]),	.pready(dev_pready[DEV_IRQ]),
		.pslverr(dev_pslverr[DEV_IRQ]),
		.irq_events(irq_events),	.irq(irq)
	);

endmodule

/* management_subsystem_properties.sv */
module mgmt_decoder_properties
	import mgmt_pkg::*;
(
	input wire						sys_clk,
	input wire						rst,
	input wire						psel,
	input wire						penable,
	input wire [ADDR_WIDTH-1:0]		paddr,
	input wire						pready,
	input wire						pslverr,
	input wire [NUM_DEVS-1:0]		dev_psel,
	input wire						ext_psel,
	input wire						ext_penable
);

	logic	unmapped_slot;

	// Slot outside the map, worked out from the raw address bits
	assign unmapped_slot = paddr[15] ? (paddr[14:12] != BIG_EXT) :
		(paddr[14:10] != SMOL_SYSINFO && paddr[14:10] != SMOL_LEDS &&
		paddr[14:10] != SMOL_IRQ);

	// Never more than one target per transfer
	assert property (@(posedge sys_clk) disable iff (rst)
		$onehot0({dev_psel[NUM_INT_DEVS-1:0], ext_psel}))
	else $error("more than one device select active");

	// External access phase only inside its own select
	assert property (@(posedge sys_clk) disable iff (rst) ext_penable |-> ext_psel)
	else $error("ext_penable without ext_psel");

	// Unmapped slots end in the access cycle with an error
	assert property (@(posedge sys_clk) disable iff (rst)
		(psel && penable && unmapped_slot) |-> (pready && pslverr))
	else $error("unmapped access without pready and pslverr");

endmodule

bind mgmt_apb_decoder mgmt_decoder_properties decoder_props(
	.sys_clk(sys_clk),		.rst(rst),
	.psel(psel),			.penable(penable),		.paddr(paddr),
	.pready(pready),		.pslverr(pslverr),
	.dev_psel(dev_psel),	.ext_psel(ext_psel),	.ext_penable(ext_penable)
);

/* management_subsystem_tb.sv */
module management_subsystem_tb
	import mgmt_pkg::*;
;

	localparam CLK_PERIOD		= 40;
	localparam REFCLK_HZ		= 1000;
	localparam GATE_CYCLES		= 500;
	localparam IRQ_COUNT		= 4;
	localparam TACH0_P			= 20;
	localparam TACH1_P			= 50;
	localparam EXT_WORDS		= 4096;
	localparam NUM_XFERS		= 90;
	localparam WATCHDOG_CYCLES	= NUM_XFERS * 20 + 6 * GATE_CYCLES;

	logic					sys_clk = 1'b0;
	logic					rst;
	logic					psel;
	logic					penable;
	logic					pwrite;
	logic [15:0]			paddr;
	logic [15:0]			pwdata;
	wire [15:0]				prdata;
	wire					pready;
	wire					pslverr;
	logic					tach0 = 1'b0;
	logic					tach1 = 1'b0;
	wire [1:0]				fan_tach;
	logic [11:0]			trig_in_led;
	logic [11:0]			trig_out_led;
	logic [3:0]				relay_state;
	logic [IRQ_COUNT-1:0]	irq_events;
	wire					irq;
	wire					ext_psel;
	wire					ext_penable;
	wire					ext_pwrite;
	wire [11:0]				ext_paddr;
	wire [15:0]				ext_pwdata;
	logic [15:0]			ext_prdata = '0;
	logic					ext_pready = 1'b1;
	wire					ext_pslverr;

	// Model state
	logic [IRQ_COUNT-1:0]	m_status;
	logic [IRQ_COUNT-1:0]	m_enable;
	logic [15:0]			m_ext [0:EXT_WORDS-1];
	string					cur_test;

	// Last finished transfer for the compare process
	event					xfer_done;
	logic					x_write;
	logic [15:0]			x_addr;
	logic [15:0]			x_data;
	logic					x_err;
	int						x_waits;
	string					x_name;

	// External peripheral stand-in
	logic [15:0]			ext_mem [0:EXT_WORDS-1];
	int						ext_wait = 0;
	logic [11:0]			ext_addr_q = '0;

	assign fan_tach		= {tach1, tach0};
	assign ext_pslverr	= 1'b0;

	management_subsystem #(
		.REFCLK_HZ(REFCLK_HZ),	.GATE_CYCLES(GATE_CYCLES),	.IRQ_COUNT(IRQ_COUNT)
	) DUT(
		.sys_clk(sys_clk),		.rst(rst),
		.psel(psel),			.penable(penable),		.pwrite(pwrite),
		.paddr(paddr),			.pwdata(pwdata),
		.prdata(prdata),		.pready(pready),		.pslverr(pslverr),
		.fan_tach(fan_tach),	.trig_in_led(trig_in_led),	.trig_out_led(trig_out_led),
		.relay_state(relay_state),	.irq_events(irq_events),	.irq(irq),
		.ext_psel(ext_psel),	.ext_penable(ext_penable),	.ext_pwrite(ext_pwrite),
		.ext_paddr(ext_paddr),	.ext_pwdata(ext_pwdata),
		.ext_prdata(ext_prdata),	.ext_pready(ext_pready),	.ext_pslverr(ext_pslverr)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// Fan tach square waves of TACH0_P and TACH1_P clocks
	always begin
		repeat (TACH0_P / 2) @(negedge sys_clk);
		tach0 = ~tach0;
	end

	always begin
		repeat (TACH1_P / 2) @(negedge sys_clk);
		tach1 = ~tach1;
	end

	////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [15:0] fill_word(input logic [11:0] a);
		return {a[3:0], a} ^ 16'h3c5a;
	endfunction

	function automatic logic [15:0] smol_addr(input logic [4:0] dev, input logic [9:0] off);
		return {1'b0, dev, off};
	endfunction

	function automatic logic [15:0] big_addr(input logic [2:0] dev, input logic [11:0] off);
		return {1'b1, dev, off};
	endfunction

	// Input LED bit i lands on bit 11 minus i
	function automatic logic [11:0] mirror12(input logic [11:0] v);
		logic [11:0] r;
		for (int i = 0; i < 12; i++)
			r[11 - i] = v[i];
		return r;
	endfunction

	// Output LEDs 8 to 11 go dark where their relay bit is set
	function automatic logic [11:0] relay_gate(input logic [11:0] leds,
		input logic [3:0] relays);
		logic [11:0] r;
		r = leds;
		for (int k = 0; k < 4; k++)
			if (relays[k])
				r[8 + k] = 1'b0;
		return r;
	endfunction

	function automatic logic is_fan_reg(input logic [15:0] addr);
		return !addr[15] && addr[14:10] == SMOL_SYSINFO &&
			(addr[9:0] == REG_FAN0 || addr[9:0] == REG_FAN1);
	endfunction

	// Expected {pslverr, prdata} of a transfer with nominal fan values
	function automatic logic [16:0] expected_read(input logic [15:0] addr, input logic write);
		logic [15:0]	data;
		logic			err;
		data	= '0;
		err		= 1'b0;
		if (addr[15]) begin
			if (addr[14:12] == BIG_EXT)
				data	= m_ext[addr[11:0]];
			else
				err		= 1'b1;
		end
		else begin
			case (addr[14:10])
				SMOL_SYSINFO: begin
					case (addr[9:0])
						REG_SYS_ID:	data	= SYSINFO_ID;
						REG_FAN0:	data	= 16'(60 * GATE_CYCLES / TACH0_P);
						REG_FAN1:	data	= 16'(60 * GATE_CYCLES / TACH1_P);
						default:	err		= 1'b1;
					endcase
					err	= err | write;
				end
				SMOL_LEDS: begin
					case (addr[9:0])
						REG_LED_IN:		data	= {4'h0, mirror12(trig_in_led)};
						REG_LED_OUT:	data	= {4'h0, relay_gate(trig_out_led, relay_state)};
						default:		err		= 1'b1;
					endcase
					err	= err | write;
				end
				SMOL_IRQ: begin
					case (addr[9:0])
						REG_IRQ_STATUS:	data	= 16'(m_status);
						REG_IRQ_ENABLE:	data	= 16'(m_enable);
						default:		err		= 1'b1;
					endcase
				end
				default:	err	= 1'b1;
			endcase
		end
		if (err)
			data	= '0;
		return {err, data};
	endfunction

	// Write side effects on the model
	task automatic model_write(input logic [15:0] addr, input logic [15:0] data);
		if (!addr[15] && addr[14:10] == SMOL_IRQ) begin
			if (addr[9:0] == REG_IRQ_STATUS)
				m_status	= m_status & ~data[IRQ_COUNT-1:0];
			else if (addr[9:0] == REG_IRQ_ENABLE)
				m_enable	= data[IRQ_COUNT-1:0];
		end
		else if (addr[15] && addr[14:12] == BIG_EXT)
			m_ext[addr[11:0]]	= data;
	endtask

	task automatic report_mismatch(input string name, input logic [15:0] exp_val,
		input logic [15:0] act_val);
		$display("CHECK FAILED %s expected 0x%04h actual 0x%04h", name, exp_val, act_val);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	////////////////////////////////////////////////////////////
	// APB requester

	task automatic apb_transfer(input logic write, input logic [15:0] addr,
		input logic [15:0] wdata);
		int waits;
		waits	= 0;
		@(negedge sys_clk);
		psel	= 1'b1;
		penable	= 1'b0;
		pwrite	= write;
		paddr	= addr;
		pwdata	= wdata;
		@(negedge sys_clk);
		penable	= 1'b1;
		@(posedge sys_clk);
		while (!pready) begin
			waits++;
			@(posedge sys_clk);
		end
		x_write	= write;
		x_addr	= addr;
		x_data	= prdata;
		x_err	= pslverr;
		x_waits	= waits;
		x_name	= cur_test;
		->xfer_done;
		if (write)
			model_write(addr, wdata);
		@(negedge sys_clk);
		psel	= 1'b0;
		penable	= 1'b0;
	endtask

	task automatic pulse_events(input logic [IRQ_COUNT-1:0] ev);
		@(negedge sys_clk);
		irq_events	= ev;
		@(negedge sys_clk);
		irq_events	= '0;
		m_status	= m_status | ev;
	endtask

	// Registered pin settles a cycle past the status change
	task automatic check_irq();
		repeat (2) @(negedge sys_clk);
		assert (irq == |(m_status & m_enable))
		else report_mismatch({cur_test, " irq"}, 16'(|(m_status & m_enable)), 16'(irq));
	endtask

	////////////////////////////////////////////////////////////
	// Compare

	always @(xfer_done) begin : compare
		logic [16:0]	exp;
		int				diff;
		exp	= expected_read(x_addr, x_write);
		assert (x_err == exp[16])
		else report_mismatch({x_name, " pslverr"}, 16'(exp[16]), 16'(x_err));
		// Only the external port may stretch a transfer
		assert (x_waits == 0 || x_addr[15])
		else report_failure({x_name, ": internal transfer took wait cycles"});
		if (!x_write) begin
			if (is_fan_reg(x_addr)) begin
				diff	= int'(x_data) - int'(exp[15:0]);
				assert (diff <= 60 && diff >= -60)
				else report_mismatch(x_name, exp[15:0], x_data);
			end
			else begin
				assert (x_data == exp[15:0])
				else report_mismatch(x_name, exp[15:0], x_data);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// External peripheral with random wait states

	initial begin
		for (int i = 0; i < EXT_WORDS; i++)
			ext_mem[i]	= fill_word(12'(i));
		forever begin
			@(posedge sys_clk);
			if (ext_psel && !ext_penable) begin
				// Offset and direction arrive as the host sent them
				assert (ext_paddr == paddr[11:0])
				else report_mismatch("ext_port ext_paddr", 16'(paddr[11:0]), 16'(ext_paddr));
				assert (ext_pwrite == pwrite)
				else report_mismatch("ext_port ext_pwrite", 16'(pwrite), 16'(ext_pwrite));
				ext_wait	= int'($urandom_range(3, 0));
				ext_addr_q	= ext_paddr;
			end
			else if (ext_penable && ext_pready) begin
				if (ext_pwrite) begin
					assert (ext_pwdata == pwdata)
					else report_mismatch("ext_port ext_pwdata", pwdata, ext_pwdata);
					ext_mem[ext_addr_q]	= ext_pwdata;
				end
			end
			else if (ext_penable)
				ext_wait	= ext_wait - 1;
		end
	end

	always @(negedge sys_clk) begin
		ext_pready	= (ext_wait == 0);
		ext_prdata	= ext_mem[ext_addr_q];
	end

	// Watchdog sized from the transfer count and the fan windows
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("Watchdog expired before the tests finished");
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [11:0] offs [0:15];
		void'($urandom(32'hf4a7b0a4));
		rst				= 1'b1;
		psel			= 1'b0;
		penable			= 1'b0;
		pwrite			= 1'b0;
		paddr			= '0;
		pwdata			= '0;
		trig_in_led		= '0;
		trig_out_led	= '0;
		relay_state		= '0;
		irq_events		= '0;
		m_status		= '0;
		m_enable		= '0;
		for (int i = 0; i < EXT_WORDS; i++)
			m_ext[i]	= fill_word(12'(i));
		repeat (8) @(negedge sys_clk);
		rst	= 1'b0;

		// Quiet outputs straight out of reset
		assert (!irq && !ext_psel && !ext_penable)
		else report_failure("irq or external select high after reset");

		// ID word and read-only errors
		cur_test	= "sysinfo";
		apb_transfer(1'b0, smol_addr(SMOL_SYSINFO, REG_SYS_ID), '0);
		apb_transfer(1'b0, smol_addr(SMOL_SYSINFO, 10'h006), '0);
		apb_transfer(1'b1, smol_addr(SMOL_SYSINFO, REG_SYS_ID), 16'h1234);
		apb_transfer(1'b1, smol_addr(SMOL_SYSINFO, REG_FAN1), 16'h5678);

		// LED mirror and relay gating
		cur_test	= "led_status";
		repeat (8) begin
			trig_in_led		= 12'($urandom);
			trig_out_led	= 12'($urandom);
			relay_state		= 4'($urandom);
			apb_transfer(1'b0, smol_addr(SMOL_LEDS, REG_LED_IN), '0);
			apb_transfer(1'b0, smol_addr(SMOL_LEDS, REG_LED_OUT), '0);
		end
		apb_transfer(1'b0, smol_addr(SMOL_LEDS, 10'h004), '0);
		apb_transfer(1'b1, smol_addr(SMOL_LEDS, REG_LED_OUT), 16'hffff);

		// Sticky events, mask and write-one-to-clear
		cur_test	= "irq_status";
		apb_transfer(1'b1, smol_addr(SMOL_IRQ, REG_IRQ_ENABLE), 16'h0005);
		apb_transfer(1'b0, smol_addr(SMOL_IRQ, REG_IRQ_ENABLE), '0);
		pulse_events(4'b0010);
		check_irq();
		apb_transfer(1'b0, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), '0);
		pulse_events(4'b0100);
		check_irq();
		apb_transfer(1'b0, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), '0);
		repeat (4) begin
			pulse_events(4'($urandom));
			check_irq();
			apb_transfer(1'b0, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), '0);
		end
		repeat (3) begin
			apb_transfer(1'b1, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), 16'($urandom_range(15, 0)));
			apb_transfer(1'b0, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), '0);
			check_irq();
		end
		apb_transfer(1'b1, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), 16'h000f);
		apb_transfer(1'b0, smol_addr(SMOL_IRQ, REG_IRQ_STATUS), '0);
		check_irq();
		apb_transfer(1'b0, smol_addr(SMOL_IRQ, 10'h004), '0);

		// External window under back-pressure
		cur_test	= "ext_port";
		for (int i = 0; i < 16; i++) begin
			offs[i]	= 12'($urandom) & 12'hffe;
			apb_transfer(1'b1, big_addr(BIG_EXT, offs[i]), 16'($urandom));
		end
		for (int i = 0; i < 16; i++)
			apb_transfer(1'b0, big_addr(BIG_EXT, offs[i]), '0);
		repeat (2)
			apb_transfer(1'b0, big_addr(BIG_EXT, 12'($urandom)), '0);

		// Holes in both windows
		cur_test	= "unmapped";
		repeat (4) begin
			apb_transfer(1'b0, smol_addr(5'($urandom_range(31, 3)), 10'h002), '0);
			apb_transfer(1'b0, big_addr(3'($urandom_range(7, 1)), 12'($urandom)), '0);
			apb_transfer(1'b1, big_addr(3'($urandom_range(7, 1)), 12'h010), 16'hbeef);
		end

		// Two full gate windows at least before reading the fans
		cur_test	= "fan_speed";
		repeat (2 * GATE_CYCLES + 10) @(negedge sys_clk);
		apb_transfer(1'b0, smol_addr(SMOL_SYSINFO, REG_FAN0), '0);
		apb_transfer(1'b0, smol_addr(SMOL_SYSINFO, REG_FAN1), '0);

		repeat (2) @(negedge sys_clk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* management_subsystem.f */
mgmt_pkg.sv
mgmt_apb_decoder.sv
fan_tachometer.sv
apb_sysinfo.sv
apb_led_status.sv
apb_irq_status.sv
management_subsystem.sv
management_subsystem_properties.sv
management_subsystem_tb.sv

/* run_sim.sh */
#!/bin/bash
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 --top-module management_subsystem_tb \
	-f management_subsystem.f -o management_subsystem_sim > build.log 2>&1 &&
	./obj_dir/management_subsystem_sim > sim.log 2>&1
grep -qx "TESTS PASSED" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
